// ==== design/sched_pkg.sv ====
// Shared types and default sizing for the packet dequeue scheduler.
// The top level picks up these defaults as its module parameters.
`default_nettype none

package sched_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Port state

    // Per-port progress through a packet
    typedef enum logic [1:0] {
        PORT_IDLE    = 2'd0,
        PORT_REQ_OUT = 2'd1,
        PORT_IN_PKT  = 2'd2
    } port_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Default sizing

    // Egress ports
    localparam int DEF_NUM_PORTS = 4;

    // Queues per port; higher index is higher priority
    localparam int DEF_QUEUES_PER_PORT = 4;

    // Bytes carried by one dequeued word
    localparam int DEF_WORD_BYTES = 64;

    // Shaper drain per cycle, in bytes
    localparam int DEF_DRAIN_BYTES = 8;

    // Framing overhead charged on the last word of a packet
    localparam int DEF_FRAME_OVERHEAD = 20;

    // Shaper debt counter width
    localparam int DEF_DEBT_WIDTH = 12;

endpackage

`default_nettype wire

// ==== design/port_fsm.sv ====
// Per-port packet state machine. Tracks whether a dequeue request is in
// flight and whether the port is part way through a packet.
`timescale 1ns/1ps
`default_nettype none

module port_fsm (
    input  logic core_clk_ifc,
    input  logic arst_n,
    input  logic grant,
    input  logic note,
    input  logic note_last,
    input  logic has_candidate,
    input  logic debt_zero,
    input  logic egr_ready,
    output logic eligible,
    output logic in_pkt
);

    import sched_pkg::*;

    port_state_t state_q;
    port_state_t state_d;

    ////////////////////////////////////////////////////////////////////////////
    // Next state

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            PORT_IDLE: begin
                if (grant) begin
                    state_d = PORT_REQ_OUT;
                end
            end
            PORT_REQ_OUT: begin
                // Word came back from the queue system
                if (note) begin
                    state_d = note_last ? PORT_IDLE : PORT_IN_PKT;
                end
            end
            PORT_IN_PKT: begin
                if (grant) begin
                    state_d = PORT_REQ_OUT;
                end
            end
            default: begin
                state_d = PORT_IDLE;
            end
        endcase
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= PORT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs

    // Only one request in flight per port
    assign eligible = (state_q != PORT_REQ_OUT) && debt_zero && egr_ready
                      && has_candidate;

    // Queue stays locked from the first grant until the last word returns
    assign in_pkt = (state_q != PORT_IDLE);

endmodule

`default_nettype wire

// ==== design/shaper_timer.sv ====
// Per-port byte-debt shaper. Each returned word charges its bytes, the
// last word also charges framing overhead, and the debt drains every cycle.
`timescale 1ns/1ps
`default_nettype none

module shaper_timer #(
    parameter int WORD_BYTES     = sched_pkg::DEF_WORD_BYTES,
    parameter int DRAIN_BYTES    = sched_pkg::DEF_DRAIN_BYTES,
    parameter int FRAME_OVERHEAD = sched_pkg::DEF_FRAME_OVERHEAD,
    parameter int DEBT_WIDTH     = sched_pkg::DEF_DEBT_WIDTH
) (
    input  logic                                core_clk_ifc,
    input  logic                                arst_n,
    input  logic                                note,
    input  logic                                note_last,
    input  logic [$clog2(WORD_BYTES+1)-1:0]     note_bytes,
    output logic                                debt_zero
);

    // One spare bit to catch overflow of the charge
    localparam int SW = DEBT_WIDTH + 1;

    logic [DEBT_WIDTH-1:0] debt_q;
    logic [DEBT_WIDTH-1:0] debt_d;
    logic [SW-1:0]         charge_sum;

    ////////////////////////////////////////////////////////////////////////////
    // Debt update

    always_comb begin
        charge_sum = SW'(debt_q) + SW'(note_bytes);
        if (note_last) begin
            charge_sum = charge_sum + SW'(FRAME_OVERHEAD);
        end

        if (note) begin
            // Saturate high rather than wrap
            debt_d = charge_sum[DEBT_WIDTH] ? '1 : charge_sum[DEBT_WIDTH-1:0];
        end else if (debt_q > DEBT_WIDTH'(DRAIN_BYTES)) begin
            debt_d = debt_q - DEBT_WIDTH'(DRAIN_BYTES);
        end else begin
            debt_d = '0;
        end
    end

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            debt_q <= '0;
        end else begin
            debt_q <= debt_d;
        end
    end

    assign debt_zero = (debt_q == '0);

endmodule

`default_nettype wire

// ==== design/prio_select.sv ====
// Strict-priority queue chooser for one port. Picks the highest non-empty
// queue for a new packet and holds that queue until the packet ends.
`timescale 1ns/1ps
`default_nettype none

module prio_select #(
    parameter int QUEUES_PER_PORT = sched_pkg::DEF_QUEUES_PER_PORT
) (
    input  logic                        core_clk_ifc,
    input  logic                        arst_n,
    input  logic [QUEUES_PER_PORT-1:0]  queue_empty,
    input  logic                        in_pkt,
    input  logic                        grant,
    output logic                        has_candidate,
    output logic [((QUEUES_PER_PORT > 1) ? $clog2(QUEUES_PER_PORT) : 1)-1:0] sel_queue
);

    localparam int QW = (QUEUES_PER_PORT > 1) ? $clog2(QUEUES_PER_PORT) : 1;

    logic [QW-1:0] pick;
    logic [QW-1:0] lock_q;

    ////////////////////////////////////////////////////////////////////////////
    // Priority encode

    // Scan upward so the highest non-empty index wins
    always_comb begin
        pick = '0;
        for (int q = 0; q < QUEUES_PER_PORT; q++) begin
            if (!queue_empty[q]) begin
                pick = QW'(q);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Packet lock

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            lock_q <= '0;
        end else if (grant) begin
            lock_q <= sel_queue;
        end
    end

    assign sel_queue = in_pkt ? lock_q : pick;

    // Mid-packet the locked queue still holds the rest of the packet
    assign has_candidate = in_pkt || !(&queue_empty);

endmodule

`default_nettype wire

// ==== design/port_rr_arbiter.sv ====
// Round-robin grant across eligible ports, plus the registered dequeue
// request that goes out to the queue system one cycle later.
`timescale 1ns/1ps
`default_nettype none

module port_rr_arbiter #(
    parameter int NUM_PORTS       = sched_pkg::DEF_NUM_PORTS,
    parameter int QUEUES_PER_PORT = sched_pkg::DEF_QUEUES_PER_PORT
) (
    input  logic                                  core_clk_ifc,
    input  logic                                  arst_n,
    input  logic [NUM_PORTS-1:0]                  eligible,
    input  logic [NUM_PORTS*((QUEUES_PER_PORT > 1) ?
                  $clog2(QUEUES_PER_PORT) : 1)-1:0] sel_queues,
    output logic [NUM_PORTS-1:0]                  grant,
    output logic                                  dq_req_valid,
    output logic [((NUM_PORTS*QUEUES_PER_PORT > 1) ?
                   $clog2(NUM_PORTS*QUEUES_PER_PORT) : 1)-1:0] dq_req_queue
);

    localparam int QW   = (QUEUES_PER_PORT > 1) ? $clog2(QUEUES_PER_PORT) : 1;
    localparam int PW   = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
    localparam int QIDW = (NUM_PORTS*QUEUES_PER_PORT > 1) ?
                          $clog2(NUM_PORTS*QUEUES_PER_PORT) : 1;

    logic [PW-1:0] rr_q;
    logic [PW-1:0] gnt_idx;
    logic          found;
    logic [QW-1:0] gnt_local;

    ////////////////////////////////////////////////////////////////////////////
    // Search

    // rr_q holds the first port to try this cycle
    always_comb begin
        int idx;
        found   = 1'b0;
        gnt_idx = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            idx = (int'(rr_q) + i) % NUM_PORTS;
            if (!found && eligible[idx]) begin
                found   = 1'b1;
                gnt_idx = PW'(idx);
            end
        end
    end

    assign grant     = found ? (NUM_PORTS'(1) << gnt_idx) : '0;
    assign gnt_local = sel_queues[gnt_idx*QW +: QW];

    ////////////////////////////////////////////////////////////////////////////
    // Pointer and request register

    always_ff @(posedge core_clk_ifc or negedge arst_n) begin
        if (!arst_n) begin
            rr_q         <= '0;
            dq_req_valid <= 1'b0;
        end else begin
            dq_req_valid <= found;
            if (found) begin
                rr_q <= (int'(gnt_idx) == NUM_PORTS - 1) ? '0 : gnt_idx + 1'b1;
            end
        end
    end

    // Global id is port base plus local index
    always_ff @(posedge core_clk_ifc) begin
        if (found) begin
            dq_req_queue <= QIDW'(int'(gnt_idx) * QUEUES_PER_PORT + int'(gnt_local));
        end
    end

endmodule

`default_nettype wire

// ==== design/pkt_scheduler.sv ====
// Top level of the dequeue scheduler. One slice per egress port feeds a
// shared round-robin arbiter that issues single-word dequeue requests.
`timescale 1ns/1ps
`default_nettype none

module pkt_scheduler #(
    parameter int NUM_PORTS       = sched_pkg::DEF_NUM_PORTS,
    parameter int QUEUES_PER_PORT = sched_pkg::DEF_QUEUES_PER_PORT,
    parameter int WORD_BYTES      = sched_pkg::DEF_WORD_BYTES,
    parameter int DRAIN_BYTES     = sched_pkg::DEF_DRAIN_BYTES,
    parameter int FRAME_OVERHEAD  = sched_pkg::DEF_FRAME_OVERHEAD,
    parameter int DEBT_WIDTH      = sched_pkg::DEF_DEBT_WIDTH
) (
    input  logic                                  core_clk_ifc,
    input  logic                                  arst_n,
    input  logic [NUM_PORTS*QUEUES_PER_PORT-1:0]  queue_empty,
    input  logic [NUM_PORTS-1:0]                  egr_ready,
    input  logic                                  dq_note_valid,
    input  logic [((NUM_PORTS*QUEUES_PER_PORT > 1) ?
                   $clog2(NUM_PORTS*QUEUES_PER_PORT) : 1)-1:0] dq_note_queue,
    input  logic [$clog2(WORD_BYTES+1)-1:0]       dq_note_bytes,
    input  logic                                  dq_note_last,
    output logic                                  dq_req_valid,
    output logic [((NUM_PORTS*QUEUES_PER_PORT > 1) ?
                   $clog2(NUM_PORTS*QUEUES_PER_PORT) : 1)-1:0] dq_req_queue
);

    localparam int QW = (QUEUES_PER_PORT > 1) ? $clog2(QUEUES_PER_PORT) : 1;
    localparam int PW = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [PW-1:0]           note_port;
    logic [NUM_PORTS-1:0]    note_pulse;
    logic [NUM_PORTS-1:0]    eligible;
    logic [NUM_PORTS-1:0]    grant;
    logic [NUM_PORTS-1:0]    debt_zero;
    logic [NUM_PORTS-1:0]    in_pkt;
    logic [NUM_PORTS-1:0]    has_candidate;
    logic [NUM_PORTS*QW-1:0] sel_queues;

    ////////////////////////////////////////////////////////////////////////////
    // Notification decode

    assign note_port = PW'(dq_note_queue / QUEUES_PER_PORT);

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            note_pulse[p] = dq_note_valid && (int'(note_port) == p);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Port slices

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_port
        port_fsm u_fsm (
            .core_clk_ifc  (core_clk_ifc),
            .arst_n        (arst_n),
            .grant         (grant[p]),
            .note          (note_pulse[p]),
            .note_last     (dq_note_last),
            .has_candidate (has_candidate[p]),
            .debt_zero     (debt_zero[p]),
            .egr_ready     (egr_ready[p]),
            .eligible      (eligible[p]),
            .in_pkt        (in_pkt[p])
        );

        shaper_timer #(
            .WORD_BYTES     (WORD_BYTES),
            .DRAIN_BYTES    (DRAIN_BYTES),
            .FRAME_OVERHEAD (FRAME_OVERHEAD),
            .DEBT_WIDTH     (DEBT_WIDTH)
        ) u_shaper (
            .core_clk_ifc (core_clk_ifc),
            .arst_n       (arst_n),
            .note         (note_pulse[p]),
            .note_last    (dq_note_last),
            .note_bytes   (dq_note_bytes),
            .debt_zero    (debt_zero[p])
        );

        prio_select #(
            .QUEUES_PER_PORT (QUEUES_PER_PORT)
        ) u_prio (
            .core_clk_ifc  (core_clk_ifc),
            .arst_n        (arst_n),
            .queue_empty   (queue_empty[p*QUEUES_PER_PORT +: QUEUES_PER_PORT]),
            .in_pkt        (in_pkt[p]),
            .grant         (grant[p]),
            .has_candidate (has_candidate[p]),
            .sel_queue     (sel_queues[p*QW +: QW])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Arbiter

    port_rr_arbiter #(
        .NUM_PORTS       (NUM_PORTS),
        .QUEUES_PER_PORT (QUEUES_PER_PORT)
    ) u_arb (
        .core_clk_ifc (core_clk_ifc),
        .arst_n       (arst_n),
        .eligible     (eligible),
        .sel_queues   (sel_queues),
        .grant        (grant),
        .dq_req_valid (dq_req_valid),
        .dq_req_queue (dq_req_queue)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
// Free-running clock source for the scheduler testbench.
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter real PERIOD_NS = 100.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== tb/pkt_scheduler_tb.sv ====
// Testbench for the dequeue scheduler. Models the queue system, replays the
// packet list from the vectors file and checks priority, lock and shaping.
`timescale 1ns/1ps
`default_nettype none

module pkt_scheduler_tb;

    import sched_pkg::*;

    localparam int NP          = DEF_NUM_PORTS;
    localparam int QPP         = DEF_QUEUES_PER_PORT;
    localparam int NQ          = NP * QPP;
    localparam int WB          = DEF_WORD_BYTES;
    localparam int DRAIN       = DEF_DRAIN_BYTES;
    localparam int OVH         = DEF_FRAME_OVERHEAD;
    localparam int QIDW        = $clog2(NQ);
    localparam int BW          = $clog2(WB + 1);
    localparam int MAX_CYCLES  = 20000;
    localparam int TAIL_CYCLES = 20;

    logic            core_clk_ifc;
    logic            arst_n;
    logic [NQ-1:0]   queue_empty;
    logic [NP-1:0]   egr_ready;
    logic            dq_note_valid;
    logic [QIDW-1:0] dq_note_queue;
    logic [BW-1:0]   dq_note_bytes;
    logic            dq_note_last;
    logic            dq_req_valid;
    logic [QIDW-1:0] dq_req_queue;

    // Queue system model state
    int pkt_len [NQ][$];
    int head_rem [NQ];
    int exp_words [NQ];
    int words_req [NQ];
    int vec_queue [$];
    int vec_len [$];
    bit pending [NP];
    int due [NP];
    int pend_q [NP];
    bit in_pkt_m [NP];
    int lock_m [NP];
    bit note_seen [NP];
    int last_note_cyc [NP];
    int last_debt [NP];
    int stall_start [NP];
    int stall_len [NP];

    // Inputs as the DUT saw them one and two cycles back
    logic [NQ-1:0] empty_last;
    logic [NQ-1:0] elig_empty;
    logic [NP-1:0] ready_last;
    logic [NP-1:0] elig_ready;

    int          cyc;
    int          push_idx;
    int          checks;
    int          errors;
    bit          overlap_seen;

    tb_clock #(.PERIOD_NS(100.0)) u_clock (.clk(core_clk_ifc));

    pkt_scheduler uut (
        .core_clk_ifc  (core_clk_ifc),
        .arst_n        (arst_n),
        .queue_empty   (queue_empty),
        .egr_ready     (egr_ready),
        .dq_note_valid (dq_note_valid),
        .dq_note_queue (dq_note_queue),
        .dq_note_bytes (dq_note_bytes),
        .dq_note_last  (dq_note_last),
        .dq_req_valid  (dq_req_valid),
        .dq_req_queue  (dq_req_queue)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    task automatic compare_value(string name, int exp, int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("Error: %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic confirm(bit cond, string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("Failure: %s", what);
        end
    endtask

    // Debt from the last note must drain before the next request
    task automatic verify_spacing(int p);
        int need;
        int gap;
        need = (last_debt[p] + DRAIN - 1) / DRAIN + 1;
        gap  = cyc - last_note_cyc[p];
        checks++;
        assert (gap >= need) else begin
            errors++;
            $display("Error: shaper_spacing port %0d expected at least %0d actual %0d",
                     p, need, gap);
        end
    endtask

    function automatic int highest_nonempty(logic [NQ-1:0] empty, int p);
        int best;
        best = -1;
        for (int i = 0; i < QPP; i++) begin
            if (!empty[p*QPP + i]) begin
                best = p*QPP + i;
            end
        end
        return best;
    endfunction

    function automatic bit drained();
        bit idle;
        idle = (push_idx == vec_queue.size());
        for (int q = 0; q < NQ; q++) begin
            idle = idle && (pkt_len[q].size() == 0);
        end
        for (int p = 0; p < NP; p++) begin
            idle = idle && !pending[p];
        end
        return idle;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Queue system model

    task automatic load_vectors();
        int    fd;
        int    q;
        int    len;
        int    words;
        string line;
        fd = $fopen("tb/sched_vectors.txt", "r");
        confirm(fd != 0, "cannot open tb/sched_vectors.txt");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                // Comment lines do not scan as three numbers
                if ($sscanf(line, "%d %d %d", q, len, words) == 3) begin
                    compare_value("vector_words", (len + WB - 1) / WB, words);
                    vec_queue.push_back(q);
                    vec_len.push_back(len);
                    exp_words[q] += words;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic handle_request(int q);
        int p;
        p = q / QPP;
        confirm(!pending[p], $sformatf("second request for port %0d before its note", p));
        confirm(elig_ready[p], $sformatf("request for port %0d while egr_ready low", p));
        if (pkt_len[q].size() == 0) begin
            confirm(1'b0, $sformatf("request for queue %0d which holds no packet", q));
            return;
        end
        if (!in_pkt_m[p]) begin
            compare_value("strict_priority", highest_nonempty(elig_empty, p), q);
            in_pkt_m[p] = 1'b1;
            lock_m[p]   = q;
        end else begin
            compare_value("packet_lock", lock_m[p], q);
        end
        if (note_seen[p]) begin
            verify_spacing(p);
        end
        for (int o = 0; o < NP; o++) begin
            if (o != p && pending[o]) begin
                overlap_seen = 1'b1;
            end
        end
        pending[p] = 1'b1;
        due[p]     = cyc + int'($urandom_range(4, 1));
        pend_q[p]  = q;
        words_req[q]++;
    endtask

    task automatic send_note(int p);
        int q;
        int b;
        bit last;
        q = pend_q[p];
        if (head_rem[q] == 0) begin
            head_rem[q] = pkt_len[q][0];
        end
        b           = (head_rem[q] < WB) ? head_rem[q] : WB;
        head_rem[q] = head_rem[q] - b;
        last        = (head_rem[q] == 0);
        dq_note_valid <= 1'b1;
        dq_note_queue <= QIDW'(q);
        dq_note_bytes <= BW'(b);
        dq_note_last  <= last;
        pending[p]       = 1'b0;
        note_seen[p]     = 1'b1;
        last_note_cyc[p] = cyc + 1;
        last_debt[p]     = b + (last ? OVH : 0);
        if (last) begin
            void'(pkt_len[q].pop_front());
            in_pkt_m[p] = 1'b0;
        end
    endtask

    // One clock of the model that observes, answers, pushes and drives
    task automatic step_cycle();
        bit            sent;
        logic [NQ-1:0] empty_n;
        logic [NP-1:0] ready_n;
        @(posedge core_clk_ifc);
        elig_empty = empty_last;
        elig_ready = ready_last;
        empty_last = queue_empty;
        ready_last = egr_ready;
        if (cyc == 0) begin
            confirm(dq_req_valid == 1'b0, "dq_req_valid high on first cycle after reset");
        end
        if (dq_req_valid) begin
            handle_request(int'(dq_req_queue));
        end
        dq_note_valid <= 1'b0;
        sent = 1'b0;
        for (int p = 0; p < NP; p++) begin
            if (!sent && pending[p] && cyc >= due[p]) begin
                send_note(p);
                sent = 1'b1;
            end
        end
        if (push_idx < vec_queue.size()) begin
            pkt_len[vec_queue[push_idx]].push_back(vec_len[push_idx]);
            push_idx++;
        end
        for (int q = 0; q < NQ; q++) begin
            empty_n[q] = (pkt_len[q].size() == 0);
        end
        for (int p = 0; p < NP; p++) begin
            ready_n[p] = !(cyc >= stall_start[p] && cyc < stall_start[p] + stall_len[p]);
        end
        queue_empty <= empty_n;
        egr_ready   <= ready_n;
        cyc++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        arst_n        = 1'b0;
        queue_empty   = '1;
        egr_ready     = '1;
        dq_note_valid = 1'b0;
        dq_note_queue = '0;
        dq_note_bytes = '0;
        dq_note_last  = 1'b0;
        ready_last    = '1;
        void'($urandom(32'h77a1));
        load_vectors();

        // First packet already waits in its queue while reset is held
        if (vec_queue.size() > 0) begin
            pkt_len[vec_queue[0]].push_back(vec_len[0]);
            push_idx = 1;
        end
        for (int q = 0; q < NQ; q++) begin
            queue_empty[q] = (pkt_len[q].size() == 0);
        end
        empty_last = queue_empty;

        for (int p = 0; p < NP; p++) begin
            stall_start[p] = int'($urandom_range(180, 30));
            stall_len[p]   = int'($urandom_range(40, 10));
        end

        for (int i = 0; i < 10; i++) begin
            @(negedge core_clk_ifc);
            confirm(dq_req_valid === 1'b0, "dq_req_valid high during reset");
        end
        @(posedge core_clk_ifc);
        arst_n <= 1'b1;

        while (!drained() && cyc < MAX_CYCLES) begin
            step_cycle();
        end
        if (!drained()) begin
            errors++;
            $display("Timeout: queues not drained within %0d cycles", MAX_CYCLES);
        end
        // Quiet window so a stray request still reaches the model
        for (int i = 0; i < TAIL_CYCLES; i++) begin
            step_cycle();
        end

        for (int q = 0; q < NQ; q++) begin
            compare_value($sformatf("words_queue_%0d", q), exp_words[q], words_req[q]);
        end
        confirm(overlap_seen, "requests for different ports never overlapped");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== pkt_scheduler.f ====
design/sched_pkg.sv
design/port_fsm.sv
design/shaper_timer.sv
design/prio_select.sv
design/port_rr_arbiter.sv
design/pkt_scheduler.sv
tb/tb_clock.sv
tb/pkt_scheduler_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the scheduler testbench with Verilator, run it, and scan the log.
# Run from anywhere; paths are taken relative to the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f pkt_scheduler.f \
    --top-module pkt_scheduler_tb -o pkt_scheduler_sim > build.log 2>&1 \
    && ./obj_dir/pkt_scheduler_sim > sim.log 2>&1 \
    || { cat build.log; [ -f sim.log ] && cat sim.log; echo "build or run failed"; exit 1; }

cat sim.log

grep -q "TB FAILED" sim.log \
    && { echo "result: fail"; exit 1; } \
    || { echo "result: pass"; exit 0; }

// ==== tb/sched_vectors.txt ====
# queue byte_length expected_words, one packet per line
# pushed one per cycle in file order; queue q belongs to port q/4
0 64 1
3 100 2
1 300 5
2 64 1
5 1 1
7 65 2
6 256 4
4 500 8
9 130 3
11 64 1
8 200 4
10 129 3
13 700 11
15 40 1
12 192 3
14 64 1
0 128 2
3 60 1
2 450 8
1 10 1
7 320 5
5 257 5
6 64 1
4 33 1
11 600 10
10 64 1
9 65 2
8 128 2
15 384 6
12 90 2
14 1000 16
13 64 1
3 256 4
7 128 2
11 193 4
15 64 1
